// File: filelist.f
+incdir+.
ooo_pkg.sv
rs_entry.sv
rs_grant_select.sv
rs.sv
alu_unit.sv
mult_unit.sv
cdb_arbiter.sv
issue_core.sv
issue_core_assertions.sv
issue_core_tb.sv

// File: Bender.yml
package:
  name: issue_core

export_include_dirs:
  - .

sources:
  - ooo_pkg.sv
  - rs_entry.sv
  - rs_grant_select.sv
  - rs.sv
  - alu_unit.sv
  - mult_unit.sv
  - cdb_arbiter.sv
  - issue_core.sv
  - target: test
    files:
      - issue_core_assertions.sv
      - issue_core_tb.sv

// File: issue_core_tb.sv
/* Directed testbench for the issue core, checks every CDB broadcast against a reference model
   Compile with filelist.f and run issue_core_tb as the top module */
`timescale 1ns/1ps
`include "ooo_params.svh"

module issue_core_tb;
	import ooo_pkg::*;

	localparam int           TIMEOUT = 100;      // Cycles any single wait may take
	localparam rs_dispatch_t NO_OP   = '0;

	logic          clock;
	logic          rst_n;
	rs_dispatch_t  dispatch1;
	rs_dispatch_t  dispatch2;
	cdb_t          cdb;
	rs_occupancy_t occupancy;

	int          cyc = 0;
	int          errors = 0;
	int          tests = 0;
	int          test_start;           // Error count when the running test began
	logic [31:0] rng = 32'h5fbc;
	rob_idx_t    next_rob = '0;

	// Modelled result per destination tag
	data_t    exp_val  [`PRF_SIZE];
	rob_idx_t exp_rob  [`PRF_SIZE];
	int       disp_cyc [`PRF_SIZE];    // Cycle the load was driven

	// CDB monitor record per tag
	int       seen_cnt [`PRF_SIZE] = '{default: 0};
	data_t    seen_val [`PRF_SIZE];
	rob_idx_t seen_rob [`PRF_SIZE];
	int       seen_cyc [`PRF_SIZE];

	issue_core i_dut (
		.clock     (clock),
		.rst_n     (rst_n),
		.dispatch1 (dispatch1),
		.dispatch2 (dispatch2),
		.cdb       (cdb),
		.occupancy (occupancy)
	);

	bind cdb_arbiter issue_core_assertions i_cdb_assert (
		.clock       (clock),
		.rst_n       (rst_n),
		.alu_result  (alu_result),
		.mult_result (mult_result),
		.alu_grant   (alu_grant),
		.mult_grant  (mult_grant),
		.cdb         (cdb)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;      // 4 ns period

	always @(posedge clock) cyc <= cyc + 1;

	// Bus is settled mid-cycle
	always @(negedge clock)
	begin
		if (rst_n && cdb.valid)
		begin
			seen_cnt[cdb.tag] = seen_cnt[cdb.tag] + 1;
			seen_val[cdb.tag] = cdb.value;
			seen_rob[cdb.tag] = cdb.rob_idx;
			seen_cyc[cdb.tag] = cyc;
		end
	end

	////////////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Two steps fill one 64-bit operand
	function automatic data_t rand_operand();
		logic [31:0] hi;
		rng = xorshift32(rng);
		hi  = rng;
		rng = xorshift32(rng);
		return data_t'({hi, rng});
	endfunction

	function automatic data_t ref_result(input alu_func_t f, input data_t a, input data_t b);
		case (f)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a - b;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_MULQ: return a * b;     // Low half of the product
			default:  return '0;
		endcase
	endfunction

	// Builds a dispatch and records what its broadcast must carry
	function automatic rs_dispatch_t make_op(input alu_func_t f, input data_t a,
		input logic a_ok, input data_t b, input logic b_ok, input tag_t dest);
		rs_dispatch_t d;
		data_t        va;
		data_t        vb;
		va = a_ok ? a : exp_val[a[TAG_W-1:0]];   // Producer's modelled value
		vb = b_ok ? b : exp_val[b[TAG_W-1:0]];
		exp_val[dest] = ref_result(f, va, vb);
		exp_rob[dest] = next_rob;
		d             = '0;
		d.load        = 1'b1;
		d.opa         = a;
		d.opa_valid   = a_ok;
		d.opb         = b;
		d.opb_valid   = b_ok;
		d.alu_func    = f;
		d.dest_tag    = dest;
		d.rob_idx     = next_rob;
		next_rob      = next_rob + 1'b1;
		return d;
	endfunction

	task automatic send(input rs_dispatch_t d1, input rs_dispatch_t d2);
		if (d1.load)
			disp_cyc[d1.dest_tag] = cyc;
		if (d2.load)
			disp_cyc[d2.dest_tag] = cyc;
		dispatch1 = d1;
		dispatch2 = d2;
		@(posedge clock);
		#1;
		dispatch1 = NO_OP;      // Loads are one-cycle strobes
		dispatch2 = NO_OP;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic wait_tag(input tag_t tag);
		int n;
		n = 0;
		while (seen_cnt[tag] == 0 && n < TIMEOUT)
		begin
			@(posedge clock);
			#1;
			n++;
		end
		if (seen_cnt[tag] == 0)
		begin
			$display("Timeout at %0t: tag %0d never appeared on the CDB", $time, tag);
			errors++;
		end
	endtask

	task automatic wait_two_free();
		int n;
		n = 0;
		while (occupancy != RS_TWO_OR_MORE_ENTRY_EMPTY && n < TIMEOUT)
		begin
			@(posedge clock);
			#1;
			n++;
		end
		if (occupancy != RS_TWO_OR_MORE_ENTRY_EMPTY)
		begin
			$display("Timeout at %0t: station never reported two free entries", $time);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("** Error at %0t: %s got %0h expected %0h", $time, name, got, want);
		errors++;
	endtask

	// Negative lat skips the latency check
	task automatic check_tag(input tag_t tag, input int lat);
		if (seen_cnt[tag] != 1)
			report_mismatch($sformatf("cdb broadcast count, tag %0d", tag), seen_cnt[tag], 1);
		if (seen_cnt[tag] != 0 && seen_val[tag] != exp_val[tag])
			report_mismatch($sformatf("cdb.value, tag %0d", tag), seen_val[tag], exp_val[tag]);
		if (seen_cnt[tag] != 0 && seen_rob[tag] != exp_rob[tag])
			report_mismatch($sformatf("cdb.rob_idx, tag %0d", tag), seen_rob[tag], exp_rob[tag]);
		if (lat >= 0 && seen_cnt[tag] != 0 && seen_cyc[tag] - disp_cyc[tag] != lat)
			report_mismatch($sformatf("cdb latency, tag %0d", tag),
				seen_cyc[tag] - disp_cyc[tag], lat);
	endtask

	task automatic check_occupancy(input rs_occupancy_t want);
		if (occupancy != want)
			report_mismatch("occupancy", occupancy, want);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%-12s finished with %0d errors", name, errors - test_start);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_single_ops();
		tag_t tag;
		test_start = errors;
		for (int i = 0; i < 5; i++)
		begin
			tag = tag_t'(1 + i);
			send(make_op(alu_func_t'(i), rand_operand(), 1'b1, rand_operand(), 1'b1, tag),
				NO_OP);
			wait_tag(tag);
			idle(3);                 // Room for a duplicate to show
			check_tag(tag, 2);
		end
		end_test("single_ops");
	endtask

	task automatic test_wakeup();
		rs_dispatch_t p;
		rs_dispatch_t c;
		test_start = errors;
		// Producer in slot 1, consumer in slot 2, same cycle
		p = make_op(ALU_ADD, rand_operand(), 1'b1, rand_operand(), 1'b1, 8);
		c = make_op(ALU_SUB, data_t'(8), 1'b0, rand_operand(), 1'b1, 9);
		send(p, c);
		// Consumer in slot 1 waits on slot 2
		p = make_op(ALU_XOR, rand_operand(), 1'b1, rand_operand(), 1'b1, 11);
		c = make_op(ALU_OR, rand_operand(), 1'b1, data_t'(11), 1'b0, 10);
		send(c, p);
		wait_tag(9);
		wait_tag(10);
		idle(3);
		check_tag(8, 2);
		check_tag(9, 4);      // Issues the cycle after the producer's broadcast
		check_tag(11, 2);
		check_tag(10, 4);
		end_test("wakeup");
	endtask

	task automatic test_mult_pipe();
		test_start = errors;
		for (int i = 0; i < 3; i++)
			send(make_op(ALU_MULQ, rand_operand(), 1'b1, rand_operand(), 1'b1,
				tag_t'(16 + i)), NO_OP);
		wait_tag(18);
		idle(3);
		for (int i = 0; i < 3; i++)
			check_tag(tag_t'(16 + i), `MULT_LAT + 1);
		for (int i = 16; i < 18; i++)
		begin
			if (seen_cyc[i] >= seen_cyc[i + 1])
			begin
				$display("Multiply tag %0d did not finish before tag %0d", i, i + 1);
				errors++;
			end
		end
		end_test("mult_pipe");
	endtask

	task automatic test_contention();
		test_start = errors;
		// Each pair is a multiply and an ALU op, results overlap on the bus
		for (int i = 0; i < 4; i++)
		begin
			wait_two_free();
			send(make_op(ALU_MULQ, rand_operand(), 1'b1, rand_operand(), 1'b1,
					tag_t'(24 + 2 * i)),
				make_op(alu_func_t'(i), rand_operand(), 1'b1, rand_operand(), 1'b1,
					tag_t'(25 + 2 * i)));
		end
		for (int i = 24; i < 32; i++)
			wait_tag(tag_t'(i));
		idle(6);
		for (int i = 24; i < 32; i++)
			check_tag(tag_t'(i), -1);
		end_test("contention");
	endtask

	task automatic test_occupancy();
		rs_dispatch_t prod;
		rs_dispatch_t extra;
		test_start = errors;
		check_occupancy(RS_TWO_OR_MORE_ENTRY_EMPTY);
		prod = make_op(ALU_ADD, rand_operand(), 1'b1, rand_operand(), 1'b1, 48);
		// Six waiters on tag 48 leave two entries
		for (int i = 0; i < 3; i++)
		begin
			send(make_op(alu_func_t'(i), data_t'(48), 1'b0, rand_operand(), 1'b1,
					tag_t'(40 + 2 * i)),
				make_op(alu_func_t'(i + 1), data_t'(48), 1'b0, rand_operand(), 1'b1,
					tag_t'(41 + 2 * i)));
			check_occupancy(RS_TWO_OR_MORE_ENTRY_EMPTY);
		end
		send(make_op(ALU_XOR, rand_operand(), 1'b1, data_t'(48), 1'b0, 46), NO_OP);
		check_occupancy(RS_ONE_ENTRY_EMPTY);
		// Producer takes the last entry, second load finds no room
		extra = make_op(ALU_OR, rand_operand(), 1'b1, rand_operand(), 1'b1, 49);
		send(prod, extra);
		check_occupancy(RS_NO_ENTRY_EMPTY);
		for (int i = 40; i < 47; i++)
			wait_tag(tag_t'(i));
		wait_two_free();
		idle(3);
		for (int i = 40; i < 47; i++)
			check_tag(tag_t'(i), -1);
		check_tag(48, 2);
		if (seen_cnt[49] != 0)
			report_mismatch("cdb broadcast count, tag 49", seen_cnt[49], 0);
		end_test("occupancy");
	endtask

	initial
	begin
		int total;
		rst_n     = 1'b0;
		dispatch1 = NO_OP;
		dispatch2 = NO_OP;
		repeat (5) @(posedge clock);
		#1;
		rst_n = 1'b1;
		if (cdb.valid !== 1'b0)
			report_mismatch("cdb.valid after reset", cdb.valid, 0);
		check_occupancy(RS_TWO_OR_MORE_ENTRY_EMPTY);

		test_single_ops();
		test_wakeup();
		test_mult_pipe();
		test_contention();
		test_occupancy();

		total = errors + i_dut.i_arb.i_cdb_assert.fail_count;
		$display("Summary: %0d tests, %0d check errors, %0d assertion failures",
			tests, errors, i_dut.i_arb.i_cdb_assert.fail_count);
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: issue_core_assertions.sv
/* Concurrent checks on the CDB grant protocol, bound into cdb_arbiter by the testbench
   fail_count tallies every failed property */
`timescale 1ns/1ps

module issue_core_assertions (
	input logic          clock,
	input logic          rst_n,
	input ooo_pkg::cdb_t alu_result,
	input ooo_pkg::cdb_t mult_result,
	input logic          alu_grant,
	input logic          mult_grant,
	input ooo_pkg::cdb_t cdb
);

	int fail_count = 0;

	// One owner of the bus per cycle
	grant_onehot: assert property (@(posedge clock) disable iff (!rst_n)
		!(alu_grant && mult_grant))
	else
	begin
		$error("ALU and multiplier granted the CDB together");
		fail_count++;
	end

	cdb_from_grant: assert property (@(posedge clock) disable iff (!rst_n)
		cdb.valid |-> (alu_grant || mult_grant))
	else
	begin
		$error("CDB valid without a granted request");
		fail_count++;
	end

	// Losing requester holds its result
	alu_hold: assert property (@(posedge clock) disable iff (!rst_n)
		(alu_result.valid && !alu_grant) |=> $stable(alu_result))
	else
	begin
		$error("ALU result changed while waiting for the CDB");
		fail_count++;
	end

	mult_hold: assert property (@(posedge clock) disable iff (!rst_n)
		(mult_result.valid && !mult_grant) |=> $stable(mult_result))
	else
	begin
		$error("Multiplier result changed while waiting for the CDB");
		fail_count++;
	end

endmodule

// File: issue_core.sv
/* Issue core top, station plus ALU and multiplier sharing one CDB
   Takes two dispatches a cycle and broadcasts one result a cycle */
`timescale 1ns/1ps

module issue_core (
	input  logic                   clock,
	input  logic                   rst_n,
	input  ooo_pkg::rs_dispatch_t  dispatch1,
	input  ooo_pkg::rs_dispatch_t  dispatch2,
	output ooo_pkg::cdb_t          cdb,
	output ooo_pkg::rs_occupancy_t occupancy
);
	import ooo_pkg::*;

	rs_issue_t alu_issue;
	rs_issue_t mult_issue;
	cdb_t      alu_result;     // Held until granted
	cdb_t      mult_result;
	logic      alu_available;
	logic      mult_available;
	logic      alu_grant;
	logic      mult_grant;

	rs i_rs (
		.clock          (clock),
		.rst_n          (rst_n),
		.dispatch1      (dispatch1),
		.dispatch2      (dispatch2),
		.cdb            (cdb),           // Wakeup source
		.alu_available  (alu_available),
		.mult_available (mult_available),
		.alu_issue      (alu_issue),
		.mult_issue     (mult_issue),
		.occupancy      (occupancy)
	);

	alu_unit i_alu (
		.clock     (clock),
		.rst_n     (rst_n),
		.issue     (alu_issue),
		.grant     (alu_grant),
		.available (alu_available),
		.result    (alu_result)
	);

	mult_unit i_mult (
		.clock     (clock),
		.rst_n     (rst_n),
		.issue     (mult_issue),
		.grant     (mult_grant),
		.available (mult_available),
		.result    (mult_result)
	);

	cdb_arbiter i_arb (
		.clock       (clock),
		.rst_n       (rst_n),
		.alu_result  (alu_result),
		.mult_result (mult_result),
		.alu_grant   (alu_grant),
		.mult_grant  (mult_grant),
		.cdb         (cdb)
	);

endmodule

// File: cdb_arbiter.sv
/* Round-robin owner of the single CDB between the ALU and the multiplier
   Grant and bus are combinational from the requests */
`timescale 1ns/1ps

module cdb_arbiter (
	input  logic          clock,
	input  logic          rst_n,
	input  ooo_pkg::cdb_t alu_result,
	input  ooo_pkg::cdb_t mult_result,
	output logic          alu_grant,
	output logic          mult_grant,
	output ooo_pkg::cdb_t cdb
);

	logic last_was_mult;    // Winner of the previous grant

	// On a conflict the unit that did not win last goes first
	assign alu_grant  = alu_result.valid && (!mult_result.valid || last_was_mult);
	assign mult_grant = mult_result.valid && (!alu_result.valid || !last_was_mult);

	assign cdb = alu_grant ? alu_result : mult_result;   // Idle bus shows mult valid low

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			last_was_mult <= 1'b1;      // ALU wins the first conflict
		else if (alu_grant || mult_grant)
			last_was_mult <= mult_grant;
	end

endmodule

// File: mult_unit.sv
/* Pipelined low-product multiplier, one partial product per stage
   Stalls as a whole while its last stage waits for the CDB */
`timescale 1ns/1ps
`include "ooo_params.svh"

module mult_unit (
	input  logic               clock,
	input  logic               rst_n,
	input  ooo_pkg::rs_issue_t issue,
	input  logic               grant,
	output logic               available,
	output ooo_pkg::cdb_t      result
);
	import ooo_pkg::*;

	localparam int CH   = (`DATA_W + `MULT_LAT - 1) / `MULT_LAT;  // Multiplier bits per stage
	localparam int PW   = CH * `MULT_LAT;                         // Padded multiplier width
	localparam int LAST = `MULT_LAT - 1;

	typedef struct packed {
		logic          valid;
		tag_t          tag;
		rob_idx_t      rob_idx;
		data_t         a;
		logic [PW-1:0] b;
		data_t         acc;      // Partial products summed so far
	} stage_t;

	stage_t [`MULT_LAT-1:0] stage;
	stage_t [`MULT_LAT-1:0] stage_d;
	logic                   advance;

	// Slice s of the multiplier times a, moved to its weight
	function automatic data_t partial(input data_t a, input logic [PW-1:0] b, input int s);
		logic [CH-1:0] chunk;
		data_t         pp;
		chunk = b[s*CH +: CH];
		pp    = a * chunk;
		return pp << (s * CH);
	endfunction

	assign advance   = !stage[LAST].valid || grant;
	assign available = advance;      // Frozen pipe takes no new op

	always_comb
	begin
		stage_d[0].valid   = issue.valid;
		stage_d[0].tag     = issue.dest_tag;
		stage_d[0].rob_idx = issue.rob_idx;
		stage_d[0].a       = issue.opa;
		stage_d[0].b       = PW'(issue.opb);
		stage_d[0].acc     = partial(issue.opa, PW'(issue.opb), 0);
		for (int s = 1; s < `MULT_LAT; s++)
		begin
			stage_d[s]     = stage[s-1];
			stage_d[s].acc = stage[s-1].acc + partial(stage[s-1].a, stage[s-1].b, s);
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < `MULT_LAT; s++)
				stage[s].valid <= 1'b0;
		end
		else if (advance)
			stage <= stage_d;       // Whole pipe moves together
	end

	// Last stage holds the finished low product
	assign result = '{valid: stage[LAST].valid, tag: stage[LAST].tag,
		rob_idx: stage[LAST].rob_idx, value: stage[LAST].acc};

endmodule

// File: alu_unit.sv
/* Single-cycle integer ALU with a result register held until the CDB takes it
   Fed by the station's adder issue port */
`timescale 1ns/1ps

module alu_unit (
	input  logic               clock,
	input  logic               rst_n,
	input  ooo_pkg::rs_issue_t issue,
	input  logic               grant,       // CDB takes the result this cycle
	output logic               available,
	output ooo_pkg::cdb_t      result
);
	import ooo_pkg::*;

	data_t alu_out;
	cdb_t  result_d;     // Next result register contents

	always_comb
	begin
		case (issue.alu_func)
			ALU_ADD: alu_out = issue.opa + issue.opb;
			ALU_SUB: alu_out = issue.opa - issue.opb;
			ALU_AND: alu_out = issue.opa & issue.opb;
			ALU_OR:  alu_out = issue.opa | issue.opb;
			ALU_XOR: alu_out = issue.opa ^ issue.opb;
			default: alu_out = '0;      // Never routed here
		endcase
	end

	assign result_d = '{valid: issue.valid, tag: issue.dest_tag,
		rob_idx: issue.rob_idx, value: alu_out};

	// Free slot, or the held result leaves this cycle
	assign available = !result.valid || grant;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			result.valid <= 1'b0;
		else if (available)
			result <= result_d;     // Loads a bubble when nothing issues
	end

endmodule

// File: rs.sv
/* Reservation station with allocation, per-unit issue select and occupancy report
   Sits between dispatch and the ALU and multiplier */
`timescale 1ns/1ps
`include "ooo_params.svh"

module rs (
	input  logic                   clock,
	input  logic                   rst_n,
	input  ooo_pkg::rs_dispatch_t  dispatch1,
	input  ooo_pkg::rs_dispatch_t  dispatch2,
	input  ooo_pkg::cdb_t          cdb,
	input  logic                   alu_available,
	input  logic                   mult_available,
	output ooo_pkg::rs_issue_t     alu_issue,
	output ooo_pkg::rs_issue_t     mult_issue,
	output ooo_pkg::rs_occupancy_t occupancy
);
	import ooo_pkg::*;

	localparam int CNT_W = $clog2(`RS_SIZE + 1);

	logic       [`RS_SIZE-1:0] free_vec;
	logic       [`RS_SIZE-1:0] ready_vec;
	logic       [`RS_SIZE-1:0] load1_vec;     // One-hot target of dispatch1
	logic       [`RS_SIZE-1:0] load2_vec;
	logic       [`RS_SIZE-1:0] alu_req;
	logic       [`RS_SIZE-1:0] mult_req;
	logic       [`RS_SIZE-1:0] alu_gnt;
	logic       [`RS_SIZE-1:0] mult_gnt;
	fu_select_t [`RS_SIZE-1:0] fu_vec;
	rs_issue_t  [`RS_SIZE-1:0] entry_vec;
	fu_select_t                fu_sel1;
	fu_select_t                fu_sel2;
	logic       [CNT_W-1:0]    free_cnt;

	// Only the quad multiply needs the multiplier
	function automatic fu_select_t unit_of(input alu_func_t func);
		return (func == ALU_MULQ) ? USE_MULTIPLIER : USE_ADDER;
	endfunction

	assign fu_sel1 = unit_of(dispatch1.alu_func);
	assign fu_sel2 = unit_of(dispatch2.alu_func);

	////////////////////////////////////////
	// Allocation
	////////////////////////////////////////

	rs_grant_select #(.SIZE(`RS_SIZE)) i_alloc_sel (
		.req  (free_vec),
		.en1  (dispatch1.load),
		.en2  (dispatch2.load),
		.gnt1 (load1_vec),
		.gnt2 (load2_vec)
	);

	for (genvar i = 0; i < `RS_SIZE; i++)
	begin : g_entry
		rs_entry i_entry (
			.clock     (clock),
			.rst_n     (rst_n),
			.load1     (load1_vec[i]),
			.load2     (load2_vec[i]),
			.dispatch1 (dispatch1),
			.dispatch2 (dispatch2),
			.fu_sel1   (fu_sel1),
			.fu_sel2   (fu_sel2),
			.cdb       (cdb),
			.issue_en  (alu_gnt[i] | mult_gnt[i]),
			.free      (free_vec[i]),
			.ready     (ready_vec[i]),
			.fu_sel    (fu_vec[i]),
			.entry     (entry_vec[i])
		);
	end

	////////////////////////////////////////
	// Issue select
	////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < `RS_SIZE; i++)
		begin
			alu_req[i]  = ready_vec[i] && (fu_vec[i] == USE_ADDER);
			mult_req[i] = ready_vec[i] && (fu_vec[i] == USE_MULTIPLIER);
		end
	end

	rs_grant_select #(.SIZE(`RS_SIZE)) i_alu_sel (
		.req  (alu_req),
		.en1  (alu_available),     // Busy unit gets nothing
		.en2  (1'b0),
		.gnt1 (alu_gnt),
		.gnt2 ()
	);

	rs_grant_select #(.SIZE(`RS_SIZE)) i_mult_sel (
		.req  (mult_req),
		.en1  (mult_available),
		.en2  (1'b0),
		.gnt1 (mult_gnt),
		.gnt2 ()
	);

	// One-hot grants drive the issue mux
	always_comb
	begin
		alu_issue  = '0;
		mult_issue = '0;
		for (int i = 0; i < `RS_SIZE; i++)
		begin
			if (alu_gnt[i])
				alu_issue = entry_vec[i];
			if (mult_gnt[i])
				mult_issue = entry_vec[i];
		end
	end

	////////////////////////////////////////
	// Occupancy
	////////////////////////////////////////

	always_comb
	begin
		free_cnt = '0;
		for (int i = 0; i < `RS_SIZE; i++)
			free_cnt = free_cnt + CNT_W'(free_vec[i]);
		if (free_cnt == '0)
			occupancy = RS_NO_ENTRY_EMPTY;
		else if (free_cnt == CNT_W'(1))
			occupancy = RS_ONE_ENTRY_EMPTY;
		else
			occupancy = RS_TWO_OR_MORE_ENTRY_EMPTY;
	end

endmodule

// File: rs_grant_select.sv
/* Two-grant priority selector, lowest index wins
   Used for entry allocation and for picking issue candidates */
`timescale 1ns/1ps

module rs_grant_select #(
	parameter int SIZE = 8
) (
	input  logic [SIZE-1:0] req,
	input  logic            en1,
	input  logic            en2,
	output logic [SIZE-1:0] gnt1,    // One-hot or zero
	output logic [SIZE-1:0] gnt2     // One-hot or zero
);

	logic [SIZE-1:0] low1;     // Lowest requester
	logic [SIZE-1:0] rest;     // Requests left after the first grant
	logic [SIZE-1:0] low2;

	// Isolate the lowest set bit with two's complement
	assign low1 = req & (~req + 1'b1);
	assign gnt1 = en1 ? low1 : '0;

	// Second grant skips whatever the first one took
	assign rest = req & ~gnt1;
	assign low2 = rest & (~rest + 1'b1);
	assign gnt2 = en2 ? low2 : '0;

endmodule

// File: rs_entry.sv
/* Single reservation station slot, holds one instruction until both operands arrive
   Instantiated RS_SIZE times inside the station */
`timescale 1ns/1ps

module rs_entry (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  load1,       // Allocated to dispatch1
	input  logic                  load2,       // Allocated to dispatch2
	input  ooo_pkg::rs_dispatch_t dispatch1,
	input  ooo_pkg::rs_dispatch_t dispatch2,
	input  ooo_pkg::fu_select_t   fu_sel1,
	input  ooo_pkg::fu_select_t   fu_sel2,
	input  ooo_pkg::cdb_t         cdb,
	input  logic                  issue_en,    // Picked for issue this cycle
	output logic                  free,
	output logic                  ready,
	output ooo_pkg::fu_select_t   fu_sel,
	output ooo_pkg::rs_issue_t    entry
);
	import ooo_pkg::*;

	rs_dispatch_t new_inst;      // Dispatch aimed at this slot
	fu_select_t   new_fu;
	logic         load_any;
	logic         live;          // Slot is loading or holding something
	logic         busy;
	data_t        opa;
	data_t        opb;
	logic         opa_valid;
	logic         opb_valid;
	alu_func_t    func;
	tag_t         dest_tag;
	rob_idx_t     rob_idx;
	data_t        src_a;         // Operand before CDB capture
	data_t        src_b;
	logic         src_a_valid;
	logic         src_b_valid;
	logic         hit_a;
	logic         hit_b;

	// Waiting operand whose producer is on the bus
	function automatic logic cdb_match(input logic op_valid, input data_t op,
		input cdb_t bus);
		return bus.valid && !op_valid && (op[TAG_W-1:0] == bus.tag);
	endfunction

	assign load_any = load1 | load2;
	assign live     = load_any | busy;
	assign new_inst = load1 ? dispatch1 : dispatch2;
	assign new_fu   = load1 ? fu_sel1 : fu_sel2;

	// A fresh dispatch can already catch its tag on the bus
	assign src_a       = load_any ? new_inst.opa : opa;
	assign src_b       = load_any ? new_inst.opb : opb;
	assign src_a_valid = load_any ? new_inst.opa_valid : opa_valid;
	assign src_b_valid = load_any ? new_inst.opb_valid : opb_valid;
	assign hit_a       = live && cdb_match(src_a_valid, src_a, cdb);
	assign hit_b       = live && cdb_match(src_b_valid, src_b, cdb);

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			busy      <= 1'b0;
			opa_valid <= 1'b0;
			opb_valid <= 1'b0;
		end
		else if (issue_en)
		begin
			busy      <= 1'b0;      // Slot frees on the issue edge
			opa_valid <= 1'b0;
			opb_valid <= 1'b0;
		end
		else if (live)
		begin
			busy      <= 1'b1;
			opa_valid <= src_a_valid | hit_a;
			opb_valid <= src_b_valid | hit_b;
		end
	end

	always_ff @(posedge clock)
	begin
		if (load_any)
		begin
			func     <= new_inst.alu_func;
			dest_tag <= new_inst.dest_tag;
			rob_idx  <= new_inst.rob_idx;
			fu_sel   <= new_fu;
		end
		opa <= hit_a ? cdb.value : src_a;   // Tag replaced by the broadcast value
		opb <= hit_b ? cdb.value : src_b;
	end

	assign free  = ~busy;
	assign ready = busy & opa_valid & opb_valid;   // No bypass from the CDB
	assign entry = '{valid: ready, opa: opa, opb: opb, alu_func: func,
		dest_tag: dest_tag, rob_idx: rob_idx};

endmodule

// File: ooo_pkg.sv
/* Types shared by the station, the execution units and the CDB
   Import into any module body that handles dispatch, issue or results */
`include "ooo_params.svh"

package ooo_pkg;

	localparam int TAG_W = $clog2(`PRF_SIZE);   // Physical register tag
	localparam int ROB_W = $clog2(`ROB_SIZE);

	typedef logic [`DATA_W-1:0] data_t;
	typedef logic [TAG_W-1:0]   tag_t;
	typedef logic [ROB_W-1:0]   rob_idx_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_MULQ,     // Goes to the multiplier
		ALU_DEFAULT
	} alu_func_t;

	typedef enum logic {
		USE_ADDER,
		USE_MULTIPLIER
	} fu_select_t;

	typedef enum logic [1:0] {
		RS_NO_ENTRY_EMPTY,
		RS_ONE_ENTRY_EMPTY,
		RS_TWO_OR_MORE_ENTRY_EMPTY
	} rs_occupancy_t;

	// Renamed instruction, an operand with valid clear holds its tag in the low bits
	typedef struct packed {
		logic      load;        // One-cycle strobe
		data_t     opa;
		logic      opa_valid;
		data_t     opb;
		logic      opb_valid;
		alu_func_t alu_func;
		tag_t      dest_tag;
		rob_idx_t  rob_idx;
	} rs_dispatch_t;

	typedef struct packed {
		logic      valid;       // Take this now
		data_t     opa;
		data_t     opb;
		alu_func_t alu_func;
		tag_t      dest_tag;
		rob_idx_t  rob_idx;
	} rs_issue_t;

	typedef struct packed {
		logic      valid;
		tag_t      tag;
		rob_idx_t  rob_idx;
		data_t     value;
	} cdb_t;

endpackage

// File: ooo_params.svh
/* Size constants shared by the issue core and its testbench
   Include wherever a station, tag, ROB or datapath width is needed */
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// Station depth
`define RS_SIZE   8

// Physical registers, a tag is log2 of this wide
`define PRF_SIZE  64

`define ROB_SIZE  32    // Reorder buffer entries
`define DATA_W    64    // Operand and result width

// Multiplier pipeline depth
`define MULT_LAT  3

`endif
